// ==== Makefile ====
# Verilator build and run of the L1 cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= l1_cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/cache_array_if.sv ====
`timescale 1ns/1ps

interface cache_array_if;
    import l1_cache_pkg::*;

    set_t       meta_raddr;
    set_t       meta_waddr;
    line_word_t data_raddr;
    line_word_t data_waddr;

    // Per way enables and write data
    logic  meta_we [WAYS];
    logic  data_we [WAYS];
    meta_t meta_wr [WAYS];
    word_t data_wr [WAYS];

    // Registered read data, one cycle after the read address
    meta_t meta_rd [WAYS];
    word_t data_rd [WAYS];

    modport ctrl (
        output meta_raddr, meta_waddr, data_raddr, data_waddr,
        output meta_we, data_we, meta_wr, data_wr,
        input  meta_rd, data_rd
    );

    modport store (
        input  meta_raddr, meta_waddr, data_raddr, data_waddr,
        input  meta_we, data_we, meta_wr, data_wr,
        output meta_rd, data_rd
    );

endinterface

// ==== hdl/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
    input  logic                         clk,
    input  logic                         rst,
    input  l1_cache_pkg::addr_t          core_req_addr,
    input  logic                         core_req_valid,
    output logic                         core_req_ready,
    output logic                         accept,
    input  l1_cache_pkg::lookup_result_t result,
    output logic                         core_resp_valid,
    output l1_cache_pkg::word_t          core_resp_rdata,
    cache_array_if.ctrl                  arr,
    output l1_cache_pkg::addr_t          mem_req_addr,
    output logic                         mem_req_wen,
    output l1_cache_pkg::word_t          mem_req_wdata,
    output l1_cache_pkg::mask_t          mem_req_wmask,
    output logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    input  l1_cache_pkg::word_t          mem_resp_rdata,
    input  logic                         mem_resp_valid,
    output logic                         mem_resp_ready
);
    import l1_cache_pkg::*;

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_READY,
        ST_WB,
        ST_WB_ACK,
        ST_REFILL,
        ST_UPDATE,
        ST_RETRY
    } state_t;

    state_t     state;
    set_t       sweep_set;
    word_sel_t  beat;
    logic       victim_q;
    logic       victim_lru_q;
    set_t       core_set;
    line_word_t core_line_word;
    logic       same_set;
    addr_t      refill_addr;
    meta_t      refill_meta;

    assign core_set       = core_req_addr[BYTE_BITS + WORD_SEL_BITS +: SET_BITS];
    assign core_line_word = core_req_addr[BYTE_BITS +: SET_BITS + WORD_SEL_BITS];

    // A hit commits its metadata one cycle late, so a following request to
    // the same set waits one cycle to read the updated arrays
    assign same_set       = result.resp_valid && (core_set == result.req_set);
    assign accept         = (state == ST_READY) && !result.miss;
    assign core_req_ready = accept && !(core_req_valid && same_set);

    assign core_resp_valid = (state == ST_READY) && result.resp_valid;
    assign core_resp_rdata = result.resp_rdata;

    assign refill_addr   = {result.req_tag, result.req_set, {(WORD_SEL_BITS + BYTE_BITS){1'b0}}};
    assign mem_req_wdata = arr.data_rd[victim_q];
    assign mem_req_wmask = '1;

    always_comb begin
        refill_meta.lru   = victim_lru_q;
        refill_meta.valid = 1'b1;
        refill_meta.dirty = 1'b0;
        refill_meta.tag   = result.req_tag;
    end

    // RAM read addresses
    always_comb begin
        arr.meta_raddr = result.req_set;
        arr.data_raddr = {result.req_set, beat};
        case (state)
            ST_READY: begin
                if (accept) begin
                    arr.meta_raddr = core_set;
                    arr.data_raddr = core_line_word;
                end
            end
            // Read one beat ahead when the current beat is taken
            ST_WB:    arr.data_raddr = {result.req_set, beat + word_sel_t'(mem_req_ready)};
            ST_RETRY: arr.data_raddr = {result.req_set, result.req_word};
            default: ;
        endcase
    end

    // RAM writes, hit commit, refill data, new metadata and the sweep
    always_comb begin
        arr.meta_waddr = result.req_set;
        arr.data_waddr = {result.req_set, result.req_word};
        for (int w = 0; w < WAYS; w++) begin
            arr.meta_we[w] = 1'b0;
            arr.data_we[w] = 1'b0;
            arr.meta_wr[w] = result.hit_meta;
            arr.data_wr[w] = result.hit_data;
            case (state)
                ST_SWEEP: begin
                    arr.meta_we[w] = 1'b1;
                    arr.meta_wr[w] = '0;
                end
                ST_READY: begin
                    arr.meta_we[w] = result.resp_valid && (result.hit_way == 1'(w));
                    arr.data_we[w] = result.resp_valid && (result.hit_way == 1'(w));
                end
                ST_REFILL: begin
                    arr.data_we[w] = mem_resp_valid && (victim_q == 1'(w));
                    arr.data_wr[w] = mem_resp_rdata;
                end
                ST_UPDATE: begin
                    arr.meta_we[w] = (victim_q == 1'(w));
                    arr.meta_wr[w] = refill_meta;
                end
                default: ;
            endcase
        end
        if (state == ST_SWEEP) begin
            arr.meta_waddr = sweep_set;
        end
        if (state == ST_REFILL) begin
            arr.data_waddr = {result.req_set, beat};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_SWEEP;
            sweep_set      <= '0;
            beat           <= '0;
            mem_req_valid  <= 1'b0;
            mem_resp_ready <= 1'b0;
        end else begin
            case (state)
                ST_SWEEP: begin
                    sweep_set <= sweep_set + 1'b1;
                    if (sweep_set == '1) begin
                        state <= ST_READY;
                    end
                end
                ST_READY: begin
                    if (result.miss) begin
                        victim_q     <= result.victim_way;
                        victim_lru_q <= result.victim_way ? !arr.meta_rd[0].lru :
                                arr.meta_rd[1].lru;
                        mem_req_valid <= 1'b1;
                        if (result.victim_needs_writeback) begin
                            mem_req_addr <= {result.victim_tag, result.req_set,
                                    {(WORD_SEL_BITS + BYTE_BITS){1'b0}}};
                            mem_req_wen  <= 1'b1;
                            state        <= ST_WB;
                        end else begin
                            mem_req_addr   <= refill_addr;
                            mem_req_wen    <= 1'b0;
                            mem_resp_ready <= 1'b1;
                            state          <= ST_REFILL;
                        end
                    end
                end
                ST_WB: begin
                    if (mem_req_ready) begin
                        beat <= beat + 1'b1;
                        if (beat == '1) begin
                            mem_req_valid  <= 1'b0;
                            mem_resp_ready <= 1'b1;
                            state          <= ST_WB_ACK;
                        end
                    end
                end
                ST_WB_ACK: begin
                    // Memory acknowledges the burst, then the line read goes out
                    if (mem_resp_valid) begin
                        mem_req_addr  <= refill_addr;
                        mem_req_wen   <= 1'b0;
                        mem_req_valid <= 1'b1;
                        state         <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (mem_req_ready) begin
                        mem_req_valid <= 1'b0;
                    end
                    if (mem_resp_valid) begin
                        beat <= beat + 1'b1;
                        if (beat == '1) begin
                            mem_resp_ready <= 1'b0;
                            state          <= ST_UPDATE;
                        end
                    end
                end
                ST_UPDATE: state <= ST_RETRY;
                ST_RETRY:  state <= ST_READY;
                default:   state <= ST_SWEEP;
            endcase
        end
    end

endmodule

// ==== hdl/cache_lookup.sv ====
`timescale 1ns/1ps

module cache_lookup (
    input  logic                        clk,
    input  logic                        rst,
    input  l1_cache_pkg::core_req_t     core_req,
    input  logic                        accept,
    input  l1_cache_pkg::meta_t         meta_rd [l1_cache_pkg::WAYS],
    input  l1_cache_pkg::word_t         data_rd [l1_cache_pkg::WAYS],
    output l1_cache_pkg::lookup_result_t result
);
    import l1_cache_pkg::*;

    core_req_t       stage;
    tag_t            req_tag;
    set_t            req_set;
    word_sel_t       req_word;
    logic [WAYS-1:0] way_hit;
    logic            hit_way;
    logic            way0_newer;
    logic            victim;
    meta_t           old_meta;
    word_t           old_word;

    // Second stage request, lines up with the RAM read data
    always_ff @(posedge clk) begin
        if (rst) begin
            stage.valid <= 1'b0;
        end else if (accept) begin
            stage <= core_req;
        end
    end

    assign req_tag  = stage.addr[BYTE_BITS + WORD_SEL_BITS + SET_BITS +: TAG_BITS];
    assign req_set  = stage.addr[BYTE_BITS + WORD_SEL_BITS +: SET_BITS];
    assign req_word = stage.addr[BYTE_BITS +: WORD_SEL_BITS];

    for (genvar w = 0; w < WAYS; w++) begin : g_cmp
        assign way_hit[w] = meta_rd[w].valid && (meta_rd[w].tag == req_tag);
    end

    assign hit_way = way_hit[1];

    // Equal LRU bits mean way 0 is the newer one
    assign way0_newer = (meta_rd[0].lru == meta_rd[1].lru);
    assign victim     = way0_newer;

    assign old_meta = meta_rd[hit_way];
    assign old_word = data_rd[hit_way];

    always_comb begin
        result.miss                   = stage.valid && !(|way_hit);
        result.resp_valid             = stage.valid && (|way_hit);
        result.hit_way                = hit_way;
        result.victim_way             = victim;
        result.victim_needs_writeback = meta_rd[victim].valid && meta_rd[victim].dirty;
        result.victim_tag             = meta_rd[victim].tag;
        result.req_set                = req_set;
        result.req_tag                = req_tag;
        result.req_word               = req_word;
        result.resp_rdata             = old_word;

        // Make the hit way newest: way 0 copies way 1, way 1 differs from way 0
        result.hit_meta       = old_meta;
        result.hit_meta.valid = 1'b1;
        result.hit_meta.dirty = old_meta.dirty || stage.wen;
        result.hit_meta.lru   = hit_way ? !meta_rd[0].lru : meta_rd[1].lru;

        // Byte merge, a read writes the old word back unchanged
        for (int b = 0; b < 8; b++) begin
            result.hit_data[b*8 +: 8] = (stage.wen && stage.wmask[b]) ?
                    stage.wdata[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

endmodule

// ==== hdl/cache_ram.sv ====
`timescale 1ns/1ps

module cache_ram #(
    parameter int  ADDR_BITS = 8,
    parameter type payload_t = logic [63:0]
) (
    input  logic                 clk,
    input  logic [ADDR_BITS-1:0] raddr,
    output payload_t             rd,
    input  logic [ADDR_BITS-1:0] waddr,
    input  logic                 we,
    input  payload_t             wr
);

    payload_t mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wr;
        end
        // Write-first, a read of the address being written sees the new value
        if (we && (waddr == raddr)) begin
            rd <= wr;
        end else begin
            rd <= mem[raddr];
        end
    end

endmodule

// ==== hdl/cache_way_store.sv ====
`timescale 1ns/1ps

module cache_way_store (
    input logic          clk,
    cache_array_if.store arr
);
    import l1_cache_pkg::*;

    // Metadata and data arrays share their addresses across the ways,
    // only the write enables and write data are per way
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_ram #(
            .ADDR_BITS (SET_BITS),
            .payload_t (meta_t)
        ) i_meta_ram (
            .clk   (clk),
            .raddr (arr.meta_raddr),
            .rd    (arr.meta_rd[w]),
            .waddr (arr.meta_waddr),
            .we    (arr.meta_we[w]),
            .wr    (arr.meta_wr[w])
        );

        cache_ram #(
            .ADDR_BITS (SET_BITS + WORD_SEL_BITS),
            .payload_t (word_t)
        ) i_data_ram (
            .clk   (clk),
            .raddr (arr.data_raddr),
            .rd    (arr.data_rd[w]),
            .waddr (arr.data_waddr),
            .we    (arr.data_we[w]),
            .wr    (arr.data_wr[w])
        );
    end

endmodule

// ==== hdl/l1_cache.sv ====
`timescale 1ns/1ps

module l1_cache (
    input  logic                clk,
    input  logic                rst,
    input  l1_cache_pkg::addr_t core_req_addr,
    input  logic                core_req_wen,
    input  l1_cache_pkg::word_t core_req_wdata,
    input  l1_cache_pkg::mask_t core_req_wmask,
    input  logic                core_req_valid,
    output logic                core_req_ready,
    output logic                core_resp_valid,
    output l1_cache_pkg::word_t core_resp_rdata,
    output l1_cache_pkg::addr_t mem_req_addr,
    output logic                mem_req_wen,
    output l1_cache_pkg::word_t mem_req_wdata,
    output l1_cache_pkg::mask_t mem_req_wmask,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    input  l1_cache_pkg::word_t mem_resp_rdata,
    input  logic                mem_resp_valid,
    output logic                mem_resp_ready
);
    import l1_cache_pkg::*;

    core_req_t      core_req;
    lookup_result_t result;
    logic           accept;

    cache_array_if arr ();

    // The stage takes a bubble when the request is held back by ready
    assign core_req.addr  = core_req_addr;
    assign core_req.wen   = core_req_wen;
    assign core_req.wdata = core_req_wdata;
    assign core_req.wmask = core_req_wmask;
    assign core_req.valid = core_req_valid && core_req_ready;

    cache_way_store i_way_store (
        .clk (clk),
        .arr (arr.store)
    );

    cache_lookup i_lookup (
        .clk      (clk),
        .rst      (rst),
        .core_req (core_req),
        .accept   (accept),
        .meta_rd  (arr.meta_rd),
        .data_rd  (arr.data_rd),
        .result   (result)
    );

    cache_controller i_controller (
        .clk             (clk),
        .rst             (rst),
        .core_req_addr   (core_req_addr),
        .core_req_valid  (core_req_valid),
        .core_req_ready  (core_req_ready),
        .accept          (accept),
        .result          (result),
        .core_resp_valid (core_resp_valid),
        .core_resp_rdata (core_resp_rdata),
        .arr             (arr.ctrl),
        .mem_req_addr    (mem_req_addr),
        .mem_req_wen     (mem_req_wen),
        .mem_req_wdata   (mem_req_wdata),
        .mem_req_wmask   (mem_req_wmask),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_resp_rdata  (mem_resp_rdata),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_ready  (mem_resp_ready)
    );

endmodule

// ==== hdl/l1_cache_pkg.sv ====
package l1_cache_pkg;

    // Cache geometry, 2 ways of 256 sets with 4 double words per line
    localparam int WAYS           = 2;
    localparam int SET_BITS       = 8;
    localparam int WORD_SEL_BITS  = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int BYTE_BITS      = 3;
    localparam int TAG_BITS       = 32 - SET_BITS - WORD_SEL_BITS - BYTE_BITS;

    typedef logic [63:0] word_t;
    typedef logic [7:0]  mask_t;
    typedef logic [31:0] addr_t;

    // Address fields, | tag | set | word | byte |
    typedef logic [TAG_BITS-1:0]               tag_t;
    typedef logic [SET_BITS-1:0]               set_t;
    typedef logic [WORD_SEL_BITS-1:0]          word_sel_t;
    typedef logic [SET_BITS+WORD_SEL_BITS-1:0] line_word_t;

    // One metadata entry per way and set
    typedef struct packed {
        logic lru;
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    typedef struct packed {
        addr_t addr;
        logic  wen;
        word_t wdata;
        mask_t wmask;
        logic  valid;
    } core_req_t;

    // What the lookup stage reports to the controller
    typedef struct packed {
        logic      miss;
        logic      hit_way;
        logic      victim_way;
        logic      victim_needs_writeback;
        tag_t      victim_tag;
        set_t      req_set;
        tag_t      req_tag;
        word_sel_t req_word;
        meta_t     hit_meta;
        word_t     hit_data;
        logic      resp_valid;
        word_t     resp_rdata;
    } lookup_result_t;

endpackage

// ==== l1_cache.f ====
hdl/l1_cache_pkg.sv
hdl/cache_array_if.sv
hdl/cache_ram.sv
hdl/cache_way_store.sv
hdl/cache_lookup.sv
hdl/cache_controller.sv
hdl/l1_cache.sv
test/tb_clock_gen.sv
test/tb_mem_model.sv
test/tb_l1_cache.sv

// ==== test/l1_cache_trace.txt ====
// op(0 read,1 write) addr wdata mask exp_rdata traffic(0 none,1 refill,2 wb+refill)
// wb_addr is the expected write-back line address when traffic is 2
0 00001000 0000000000000000 00 000000005a5a0200 1 00000000
0 00001008 0000000000000000 00 000000005a5a0201 0 00000000
0 00001018 0000000000000000 00 000000005a5a0203 0 00000000
1 00001008 1122334455667788 0f 0000000000000000 0 00000000
0 00001008 0000000000000000 00 0000000055667788 0 00000000
1 00001010 aabbccddeeff0011 f0 0000000000000000 0 00000000
0 00001010 0000000000000000 00 aabbccdd5a5a0202 0 00000000
0 00000200 0000000000000000 00 000000005a5a0040 1 00000000
0 00002200 0000000000000000 00 000000005a5a0440 1 00000000
0 00000200 0000000000000000 00 000000005a5a0040 0 00000000
0 00004200 0000000000000000 00 000000005a5a0840 1 00000000
0 00000200 0000000000000000 00 000000005a5a0040 0 00000000
0 00002200 0000000000000000 00 000000005a5a0440 1 00000000
0 00003000 0000000000000000 00 000000005a5a0600 1 00000000
0 00005000 0000000000000000 00 000000005a5a0a00 2 00001000
0 00001008 0000000000000000 00 0000000055667788 1 00000000
1 00005018 0123456789abcdef ff 0000000000000000 0 00000000
0 00007000 0000000000000000 00 000000005a5a0e00 1 00000000
0 00009000 0000000000000000 00 000000005a5a1200 2 00005000
0 00005018 0000000000000000 00 0123456789abcdef 1 00000000
1 0000b008 ffffffffffffffff 01 0000000000000000 1 00000000
0 0000b008 0000000000000000 00 000000005a5a16ff 0 00000000

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #20 clk = ~clk;
    end

endmodule

// ==== test/tb_l1_cache.sv ====
`timescale 1ns/1ps

module tb_l1_cache;
    import l1_cache_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int SWEEP_CYCLES    = 256;
    localparam int CYCLES_PER_LINE = 300;

    logic  clk;
    logic  rst;
    addr_t core_req_addr;
    logic  core_req_wen;
    word_t core_req_wdata;
    mask_t core_req_wmask;
    logic  core_req_valid;
    logic  core_req_ready;
    logic  core_resp_valid;
    word_t core_resp_rdata;
    addr_t mem_req_addr;
    logic  mem_req_wen;
    word_t mem_req_wdata;
    mask_t mem_req_wmask;
    logic  mem_req_valid;
    logic  mem_req_ready;
    word_t mem_resp_rdata;
    logic  mem_resp_valid;
    logic  mem_resp_ready;

    // Trace columns
    logic [3:0] tr_op [$];
    addr_t      tr_addr [$];
    word_t      tr_wdata [$];
    mask_t      tr_mask [$];
    word_t      tr_rdata [$];
    logic [1:0] tr_traffic [$];
    addr_t      tr_wb_addr [$];
    bit         trace_loaded;

    // Expected memory image as seen through the cache
    word_t shadow [addr_t];

    tb_clock_gen i_clock_gen (
        .clk (clk)
    );

    tb_mem_model i_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wen    (mem_req_wen),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_rdata (mem_resp_rdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_ready (mem_resp_ready)
    );

    l1_cache i_l1_cache (
        .clk             (clk),
        .rst             (rst),
        .core_req_addr   (core_req_addr),
        .core_req_wen    (core_req_wen),
        .core_req_wdata  (core_req_wdata),
        .core_req_wmask  (core_req_wmask),
        .core_req_valid  (core_req_valid),
        .core_req_ready  (core_req_ready),
        .core_resp_valid (core_resp_valid),
        .core_resp_rdata (core_resp_rdata),
        .mem_req_addr    (mem_req_addr),
        .mem_req_wen     (mem_req_wen),
        .mem_req_wdata   (mem_req_wdata),
        .mem_req_wmask   (mem_req_wmask),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_resp_rdata  (mem_resp_rdata),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_ready  (mem_resp_ready)
    );

    task automatic abort_run(string reason);
        if (reason != "") begin
            $display("%s", reason);
        end
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(word_t exp, word_t got, string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s read data %h, expected %h", $time, what, got, exp);
            abort_run("");
        end
    endtask

    task automatic check_traffic(logic [1:0] exp, logic [1:0] got, string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s memory traffic code %0d, expected %0d",
                    $time, what, got, exp);
            abort_run("");
        end
    endtask

    task automatic check_line(addr_t exp_addr, addr_t got_addr, word_t exp_data,
            word_t got_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            $display("[FAIL] %0t ns: write-back beat %h = %h, expected %h = %h",
                    $time, got_addr, got_data, exp_addr, exp_data);
            abort_run("");
        end
    endtask

    task automatic check_mask(mask_t exp, mask_t got);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: write-back byte mask %h, expected %h", $time, got, exp);
            abort_run("");
        end
    endtask

    function automatic word_t expected_word(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {32'h0, (a >> 3) ^ 32'h5a5a_0000};
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wdata, mask_t wmask);
        word_t res;
        for (int b = 0; b < 8; b++) begin
            res[b*8 +: 8] = wmask[b] ? wdata[b*8 +: 8] : old[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic load_trace();
        int         fd;
        int         n;
        string      line;
        logic [3:0] op;
        addr_t      a;
        word_t      wd;
        mask_t      m;
        word_t      ex;
        logic [1:0] tr;
        addr_t      wa;
        fd = $fopen("test/l1_cache_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the trace file test/l1_cache_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 1 && line[0] != 8'h2f) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", op, a, wd, m, ex, tr, wa);
                    if (n == 7) begin
                        tr_op.push_back(op);
                        tr_addr.push_back(a);
                        tr_wdata.push_back(wd);
                        tr_mask.push_back(m);
                        tr_rdata.push_back(ex);
                        tr_traffic.push_back(tr);
                        tr_wb_addr.push_back(wa);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_access(int idx);
        int         reads0;
        int         writes0;
        int         dr;
        int         dw;
        int         waited;
        logic [1:0] code;
        addr_t      la;
        string      what;
        what    = $sformatf("trace line %0d", idx);
        reads0  = i_mem.read_bursts;
        writes0 = i_mem.write_bursts;
        @(posedge clk);
        #2;
        core_req_addr  = tr_addr[idx];
        core_req_wen   = tr_op[idx][0];
        core_req_wdata = tr_wdata[idx];
        core_req_wmask = tr_mask[idx];
        core_req_valid = 1'b1;
        @(negedge clk);
        while (!core_req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        core_req_valid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!core_resp_valid) begin
            waited++;
            @(negedge clk);
        end
        dr = i_mem.read_bursts - reads0;
        dw = i_mem.write_bursts - writes0;
        if (dr == 0 && dw == 0) begin
            code = 2'd0;
        end else if (dr == 1 && dw == 0) begin
            code = 2'd1;
        end else if (dr == 1 && dw == 1) begin
            code = 2'd2;
        end else begin
            code = 2'd3;
        end
        check_traffic(tr_traffic[idx], code, what);
        // A hit answers in the cycle after acceptance
        if (tr_traffic[idx] == 2'd0 && waited != 0) begin
            abort_run($sformatf("%s: the hit response came %0d cycles late", what, waited));
        end
        if (dw == 1) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                la = tr_wb_addr[idx] + addr_t'(k * 8);
                check_line(la, i_mem.wb_addr[k], expected_word(la), i_mem.wb_data[k]);
            end
        end
        if (tr_op[idx][0]) begin
            la = tr_addr[idx] & ~addr_t'(7);
            shadow[la] = merge_bytes(expected_word(la), tr_wdata[idx], tr_mask[idx]);
        end else begin
            check_word(tr_rdata[idx], core_resp_rdata, what);
        end
    endtask

    // Write-back beats carry a full byte mask
    always @(negedge clk) begin
        if (!rst && mem_req_valid && mem_req_ready && mem_req_wen) begin
            check_mask(mask_t'('1), mem_req_wmask);
        end
    end

    // Watchdog sized from the trace length
    initial begin
        wait (trace_loaded);
        repeat (RESET_CYCLES + SWEEP_CYCLES + CYCLES_PER_LINE * tr_op.size()) @(posedge clk);
        abort_run("Timeout: the test did not finish in time, the DUT appears to hang");
    end

    initial begin
        rst            = 1'b1;
        core_req_addr  = '0;
        core_req_wen   = 1'b0;
        core_req_wdata = '0;
        core_req_wmask = '0;
        core_req_valid = 1'b0;
        trace_loaded   = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        // The core is held off and memory stays quiet during the tag sweep
        repeat (SWEEP_CYCLES) begin
            @(negedge clk);
            if (core_req_ready || mem_req_valid) begin
                abort_run("The cache accepted a request or used memory during the tag sweep");
            end
        end
        for (int i = 0; i < tr_op.size(); i++) begin
            run_access(i);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                clk,
    input  logic                rst,
    input  l1_cache_pkg::addr_t mem_req_addr,
    input  logic                mem_req_wen,
    input  l1_cache_pkg::word_t mem_req_wdata,
    input  logic                mem_req_valid,
    output logic                mem_req_ready,
    output l1_cache_pkg::word_t mem_resp_rdata,
    output logic                mem_resp_valid,
    input  logic                mem_resp_ready
);
    import l1_cache_pkg::*;

    integer seed;
    word_t  mem [addr_t];
    word_t  resp_q [$];
    int     wr_beat;
    int     read_bursts;
    int     write_bursts;
    // Last write burst, one entry per beat
    addr_t  wb_addr [WORDS_PER_LINE];
    word_t  wb_data [WORDS_PER_LINE];

    // Untouched words hold their word address XOR a fixed pattern
    function automatic word_t read_word(addr_t a);
        addr_t wa;
        wa = a & ~addr_t'(7);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return {32'h0, (wa >> 3) ^ 32'h5a5a_0000};
    endfunction

    initial begin
        seed           = 32'h3b11b24d;
        wr_beat        = 0;
        read_bursts    = 0;
        write_bursts   = 0;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (mem_resp_valid && mem_resp_ready) begin
                void'(resp_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_wen) begin
                    wb_addr[wr_beat] = mem_req_addr + addr_t'(wr_beat * 8);
                    wb_data[wr_beat] = mem_req_wdata;
                    mem[wb_addr[wr_beat]] = mem_req_wdata;
                    wr_beat++;
                    if (wr_beat == WORDS_PER_LINE) begin
                        // One acknowledge beat closes the write burst
                        wr_beat = 0;
                        write_bursts++;
                        resp_q.push_back('0);
                    end
                end else begin
                    for (int i = 0; i < WORDS_PER_LINE; i++) begin
                        resp_q.push_back(read_word(mem_req_addr + addr_t'(i * 8)));
                    end
                    read_bursts++;
                end
            end
        end
        #2;
        mem_req_ready  = !rst && (($random(seed) & 3) != 0);
        mem_resp_valid = (resp_q.size() > 0);
        mem_resp_rdata = (resp_q.size() > 0) ? resp_q[0] : '0;
    end

endmodule
